// ==== design/spi_slave_consts.svh ====
`ifndef SPI_SLAVE_CONSTS_SVH
`define SPI_SLAVE_CONSTS_SVH

// ####################
// register map
// ####################
`define SPI_CONFIG      6'd0    // config byte
`define SPI_STATUS      6'd1    // status byte
`define SPI_CORE_BASE   6'd8    // core readback bytes 8..15
`define SPI_USER_BASE   6'd32   // user bytes 32..63

// ####################
// widths
// ####################
`define SPI_AW          32                  // mesh address width
`define SPI_PW          (2*`SPI_AW+40)      // full mesh packet

// command byte bits 7:6
`define SPI_CMD_WRITE   2'b00
`define SPI_CMD_READ    2'b10

// ####################
// config bit positions
// ####################
`define SPI_CFG_DISABLE   0   // spi off
`define SPI_CFG_IRQEN     1
`define SPI_CFG_CPOL      2   // idle sclk level
`define SPI_CFG_CPHA      3   // sample on trailing edge
`define SPI_CFG_LSBFIRST  4
`define SPI_CFG_EMODE     6   // bit 5 is kept but not decoded

`endif

// ==== design/spi_slave_pkg.sv ====
`default_nettype none

`include "spi_slave_consts.svh"

package spi_slave_pkg;

   // decoded config bits with spi_disable in bit 0
   typedef struct packed {
      logic emode;        // auto mode for the node
      logic lsbfirst;     // shift lsb first
      logic cpha;         // clock phase
      logic cpol;         // clock polarity
      logic irq_en;       // level irq enable
      logic spi_disable;  // spi port off
   } spi_cfg_t;

   // one host access with single cycle wr/rd strobes
   typedef struct packed {
      logic       wr;     // write strobe
      logic       rd;     // read strobe
      logic [5:0] addr;   // current byte address
      logic [7:0] wdata;  // write byte
   } spi_access_t;

   // word deposited by the core
   // data sits in the low half so byte 8 is data lsb
   typedef struct packed {
      logic [`SPI_AW-1:0] srcaddr;
      logic [`SPI_AW-1:0] data;
   } core_word_t;

   // mesh packet as it arrives from the core side
   typedef struct packed {
      logic [`SPI_PW-3*`SPI_AW-1:0] ctrl;  // 8 ctrl bits
      logic [`SPI_AW-1:0]           dstaddr;
      logic [`SPI_AW-1:0]           data;
      logic [`SPI_AW-1:0]           srcaddr;
   } emesh_packet_t;

endpackage

`default_nettype wire

// ==== design/spi_slave_io.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_slave_consts.svh"

module spi_slave_io
  (
   input  wire                          clk,
   input  wire                          nreset,
   input  wire                          sclk,    // host clock pin
   input  wire                          ss_n,    // select, low active
   input  wire                          mosi,
   output logic                         miso,
   input  wire spi_slave_pkg::spi_cfg_t cfg,     // cpol/cpha/lsbfirst used here
   input  wire [7:0]                    rdata,   // byte at access.addr
   output spi_slave_pkg::spi_access_t   access
   );

   // ####################
   // pin synchronizers
   // ####################
   logic [1:0] sclk_sync;
   logic [1:0] ss_sync;
   logic [1:0] mosi_sync;
   logic       sclk_q;      // previous synced sclk

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sclk_sync <= 2'b00;
         ss_sync   <= 2'b11;  // deselected
         mosi_sync <= 2'b00;
         sclk_q    <= 1'b0;
      end
      else
      begin
         sclk_sync <= {sclk_sync[0], sclk};
         ss_sync   <= {ss_sync[0], ss_n};
         mosi_sync <= {mosi_sync[0], mosi};
         sclk_q    <= sclk_sync[1];
      end
   end

   logic       frame_act;
   logic       lead_edge;
   logic       trail_edge;
   logic       sample_edge;
   logic       shift_edge;

   assign frame_act  = ~ss_sync[1];
   // leading edge leaves the cpol idle level
   assign lead_edge  = (sclk_sync[1] ^ cfg.cpol) & ~(sclk_q ^ cfg.cpol);
   assign trail_edge = ~(sclk_sync[1] ^ cfg.cpol) & (sclk_q ^ cfg.cpol);

   // cpha=0 samples on leading edge, shifts on trailing
   assign sample_edge = frame_act & (cfg.cpha ? trail_edge : lead_edge);
   assign shift_edge  = frame_act & (cfg.cpha ? lead_edge : trail_edge);

   // ####################
   // byte framing
   // ####################
   logic [2:0] bit_cnt;     // bits sampled in this byte
   logic       data_phase;  // command byte done
   logic       load_pend;   // next shift edge loads tx
   logic       byte_done;   // bumps addr after a data byte
   logic [1:0] op;
   logic [5:0] addr;
   logic       wr_q;
   logic       rd_q;
   logic [7:0] wdata_q;
   logic [7:0] rx;
   logic [7:0] rx_next;
   logic [7:0] tx;
   logic       last_bit;
   logic       first_bit;
   logic       is_read;
   logic       is_write;

   assign rx_next   = cfg.lsbfirst ? {mosi_sync[1], rx[7:1]} : {rx[6:0], mosi_sync[1]};
   assign last_bit  = (bit_cnt == 3'd7);
   assign first_bit = (bit_cnt == 3'd0);
   assign is_read   = data_phase & (op == `SPI_CMD_READ);
   assign is_write  = data_phase & (op == `SPI_CMD_WRITE);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         bit_cnt    <= 3'd0;
         data_phase <= 1'b0;
         load_pend  <= 1'b0;
         byte_done  <= 1'b0;
         op         <= 2'b00;
         addr       <= 6'd0;
         wr_q       <= 1'b0;
         rd_q       <= 1'b0;
         tx         <= 8'd0;
      end
      else if (!frame_act)
      begin
         // ss_n high drops any partial byte
         bit_cnt    <= 3'd0;
         data_phase <= 1'b0;
         load_pend  <= 1'b0;
         byte_done  <= 1'b0;
         wr_q       <= 1'b0;
         rd_q       <= 1'b0;
         tx         <= 8'd0;
      end
      else
      begin
         wr_q      <= sample_edge & last_bit & is_write;   // 3 clk after last sclk edge
         rd_q      <= sample_edge & first_bit & is_read;
         byte_done <= sample_edge & last_bit & data_phase;
         if (sample_edge)
         begin
            bit_cnt <= bit_cnt + 3'd1;
            if (last_bit)
            begin
               load_pend  <= 1'b1;
               data_phase <= 1'b1;
               if (!data_phase)
               begin
                  op   <= rx_next[7:6];  // command byte
                  addr <= rx_next[5:0];
               end
            end
         end
         if (byte_done)
            addr <= addr + 6'd1;  // wraps 63 -> 0
         if (shift_edge)
         begin
            if (load_pend)
            begin
               tx        <= is_read ? rdata : 8'd0;
               load_pend <= 1'b0;
            end
            else if (!first_bit)
               tx <= cfg.lsbfirst ? {1'b0, tx[7:1]} : {tx[6:0], 1'b0};
         end
      end
   end

   // payload regs
   always_ff @(posedge clk)
   begin
      if (sample_edge)
         rx <= rx_next;
      if (sample_edge & last_bit)
         wdata_q <= rx_next;
   end

   assign access = '{wr: wr_q, rd: rd_q, addr: addr, wdata: wdata_q};
   assign miso   = frame_act & (cfg.lsbfirst ? tx[0] : tx[7]);

   // op decode keeps the two strobes apart
   a_wr_rd_excl : assert property (@(posedge clk) disable iff (!nreset)
                                   !(access.wr && access.rd));

endmodule

`default_nettype wire

// ==== design/emesh_packet_unpack.sv ====
`timescale 1ns/100ps
`default_nettype none

module emesh_packet_unpack
  (
   input  wire                               clk,
   input  wire                               nreset,
   input  wire                               access_in,  // one cycle pulse
   input  wire spi_slave_pkg::emesh_packet_t packet_in,
   output logic                              core_valid,
   output spi_slave_pkg::core_word_t         core_word
   );

   // ####################
   // strobe
   // ####################

   // follows access_in by one clk
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         core_valid <= 1'b0;
      end
      else
      begin
         core_valid <= access_in;
      end
   end

   // ####################
   // payload
   // ####################

   // ctrl and dstaddr have no use at the register port
   always_ff @(posedge clk)
   begin
      if (access_in)
      begin
         core_word <= '{srcaddr: packet_in.srcaddr,  // upper 4 readback bytes
                        data:    packet_in.data};    // lower 4
      end
   end

endmodule

`default_nettype wire

// ==== design/spi_slave_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_slave_consts.svh"

module spi_slave_regs
  (
   input  wire                             clk,
   input  wire                             nreset,
   input  wire spi_slave_pkg::spi_access_t access,      // host side strobes
   input  wire                             core_valid,  // core word strobe
   input  wire spi_slave_pkg::core_word_t  core_word,
   output logic [7:0]                      rdata,       // combinational readback
   output spi_slave_pkg::spi_cfg_t         cfg,
   output logic                            irq
   );

   import spi_slave_pkg::*;

   logic [7:0] spi_config;
   logic       data_ready;        // status bit 0
   core_word_t core_q;
   logic [63:0] core_bits;
   logic [7:0] user_mem [0:31];   // no reset

   logic       config_wr;
   logic       user_wr;
   logic       status_rd;
   logic       core_hit;

   // ####################
   // host decode
   // ####################
   assign config_wr = access.wr & (access.addr == `SPI_CONFIG);
   assign user_wr   = access.wr & (access.addr >= `SPI_USER_BASE);
   assign status_rd = access.rd & (access.addr == `SPI_STATUS);
   assign core_hit  = ((access.addr & 6'h38) == `SPI_CORE_BASE);  // 8..15
   // writes to status, core or reserved fall through

   // config is zero after reset
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         spi_config <= 8'd0;
      else if (config_wr)
         spi_config <= access.wdata;
   end

   // ####################
   // status and core word
   // ####################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         data_ready <= 1'b0;
         core_q     <= '0;
      end
      else
      begin
         if (core_valid)
         begin
            data_ready <= 1'b1;        // set beats read clear
            core_q     <= core_word;
         end
         else if (status_rd)
            data_ready <= 1'b0;        // host has seen it
      end
   end

   // user bytes 32..63
   always_ff @(posedge clk)
   begin
      if (user_wr)
         user_mem[access.addr[4:0]] <= access.wdata;  // base is 32 so low bits index
   end

   // ####################
   // readback
   // ####################
   assign core_bits = core_q;

   always_comb
   begin
      if (access.addr == `SPI_CONFIG)
         rdata = spi_config;
      else if (access.addr == `SPI_STATUS)
         rdata = {7'd0, data_ready};
      else if (core_hit)
         rdata = core_bits[8*access.addr[2:0] +: 8];  // lsb byte first
      else if (access.addr >= `SPI_USER_BASE)
         rdata = user_mem[access.addr[4:0]];
      else
         rdata = 8'd0;                                // reserved
   end

   // config fields out
   assign cfg = '{emode:       spi_config[`SPI_CFG_EMODE],
                  lsbfirst:    spi_config[`SPI_CFG_LSBFIRST],
                  cpha:        spi_config[`SPI_CFG_CPHA],
                  cpol:        spi_config[`SPI_CFG_CPOL],
                  irq_en:      spi_config[`SPI_CFG_IRQEN],
                  spi_disable: spi_config[`SPI_CFG_DISABLE]};

   assign irq = cfg.irq_en & data_ready;  // level irq

   // core side strobe comes from the unpacker and must be clean
   a_core_valid_known : assert property (@(posedge clk) disable iff (!nreset)
                                         !$isunknown(core_valid));

endmodule

`default_nettype wire

// ==== design/spi_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_slave
  (
   input  wire                               clk,
   input  wire                               nreset,
   input  wire                               sclk,
   input  wire                               ss_n,
   input  wire                               mosi,
   output logic                              miso,
   input  wire                               access_in,   // core packet strobe
   input  wire spi_slave_pkg::emesh_packet_t packet_in,
   output logic                              irq,
   output logic                              spi_en,
   output spi_slave_pkg::spi_cfg_t           cfg
   );

   import spi_slave_pkg::*;

   spi_access_t access;      // io -> regs
   logic [7:0]  rdata;       // regs -> io
   logic        core_valid;
   core_word_t  core_word;

   // ####################
   // serial front end
   // ####################
   spi_slave_io u_io
     (.clk(clk), .nreset(nreset), .sclk(sclk), .ss_n(ss_n), .mosi(mosi),
      .miso(miso), .cfg(cfg), .rdata(rdata), .access(access));

   // core packet side
   emesh_packet_unpack u_unpack
     (.clk(clk), .nreset(nreset), .access_in(access_in), .packet_in(packet_in),
      .core_valid(core_valid), .core_word(core_word));

   // ####################
   // register file
   // ####################
   spi_slave_regs u_regs
     (.clk(clk), .nreset(nreset), .access(access), .core_valid(core_valid),
      .core_word(core_word), .rdata(rdata), .cfg(cfg), .irq(irq));

   assign spi_en = ~cfg.spi_disable;  // high out of reset

endmodule

`default_nettype wire

// ==== verification/spi_slave_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "spi_slave_consts.svh"

module spi_slave_tb;

   import spi_slave_pkg::*;

   localparam int HALF_CYC  = 4;             // sclk half period in clk cycles
   localparam int BIT_NS    = 2*HALF_CYC*4;  // 32 ns per sclk bit
   localparam int RESET_CYC = 10;

   localparam logic [2:0] OP_WR    = 3'd0;
   localparam logic [2:0] OP_RD    = 3'd1;
   localparam logic [2:0] OP_CORE  = 3'd2;
   localparam logic [2:0] OP_MODE  = 3'd3;   // config write then host switches
   localparam logic [2:0] OP_ABORT = 3'd4;   // ss_n up after 4 bits

   typedef struct packed {
      logic [2:0]  op;
      logic [5:0]  addr;
      logic [3:0]  len;        // data bytes in frame
      logic [63:0] data;       // byte 0 in bits 7:0
      logic [63:0] exp_bytes;  // expected miso bytes
      logic [7:0]  exp_cfg;    // config byte after the step
      logic        exp_irq;
   } step_t;

   logic          clk;
   logic          nreset;
   logic          sclk;
   logic          ss_n;
   logic          mosi;
   logic          miso;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          irq;
   logic          spi_en;
   spi_cfg_t      cfg;

   step_t       steps [0:63];
   int          n_steps;
   logic [7:0]  tx_buf [0:8];
   logic [7:0]  rx_buf [0:8];
   logic        host_cpol;
   logic        host_cpha;
   logic        host_lsb;
   integer      seed;
   int          val_errs;
   logic        table_ready;

   // reference model
   logic [7:0]  m_cfg;
   logic        m_ready;         // status bit 0
   logic [63:0] m_core;          // srcaddr over data
   logic [7:0]  m_user [0:31];

   spi_slave u_spi_slave
     (.clk(clk), .nreset(nreset), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
      .access_in(access_in), .packet_in(packet_in), .irq(irq), .spi_en(spi_en), .cfg(cfg));

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns
   end

   // ####################
   // reference model
   // ####################
   function automatic logic [7:0] model_read(input logic [5:0] a);
      logic [7:0] v;
      v = 8'd0;  // reserved
      if (a == `SPI_CONFIG)
         v = m_cfg;
      else if (a == `SPI_STATUS)
      begin
         v       = {7'd0, m_ready};
         m_ready = 1'b0;  // host read clears it
      end
      else if (a >= 6'd8 && a <= 6'd15)
         v = m_core[8*(int'(a)-8) +: 8];  // data lsb first then srcaddr
      else if (a >= `SPI_USER_BASE)
         v = m_user[int'(a)-32];
      return v;
   endfunction

   function automatic void model_write(input logic [5:0] a, input logic [7:0] d);
      if (a == `SPI_CONFIG)
         m_cfg = d;
      else if (a >= `SPI_USER_BASE)
         m_user[int'(a)-32] = d;  // status core and reserved keep their value
   endfunction

   function automatic void add_step(input logic [2:0] op, input logic [5:0] addr,
                                    input int len, input logic [63:0] data);
      step_t      s;
      logic [5:0] a;
      s      = '0;
      s.op   = op;
      s.addr = addr;
      s.len  = 4'(len);
      s.data = data;
      for (int i = 0; i < len; i++)
      begin
         a = addr + 6'(i);  // wraps 63 -> 0
         if (op == OP_WR)
            model_write(a, data[8*i +: 8]);
         else if (op == OP_RD)
            s.exp_bytes[8*i +: 8] = model_read(a);
      end
      if (op == OP_CORE)
      begin
         m_core  = data;
         m_ready = 1'b1;
      end
      else if (op == OP_MODE)
         model_write(`SPI_CONFIG, data[7:0]);
      s.exp_cfg = m_cfg;
      s.exp_irq = m_cfg[`SPI_CFG_IRQEN] & m_ready;
      steps[n_steps] = s;
      n_steps++;
   endfunction

   // random write then read back inside 32..63
   function automatic void add_burst();
      int          len;
      logic [5:0]  start;
      logic [63:0] d;
      len   = 1 + ($random(seed) & 7);
      start = 6'(32 + ($unsigned($random(seed)) % (33 - len)));
      d     = {$random(seed), $random(seed)};
      add_step(OP_WR, start, len, d);
      add_step(OP_RD, start, len, 64'd0);
   endfunction

   // ####################
   // stimulus table
   // ####################
   function automatic void build_table();
      logic [7:0] modes [0:7];
      // last entry also sets disable and emode
      modes   = '{8'h06, 8'h0a, 8'h0e, 8'h12, 8'h16, 8'h1a, 8'h1e, 8'h63};
      n_steps = 0;
      m_cfg   = 8'd0;
      m_ready = 1'b0;
      m_core  = 64'd0;
      add_step(OP_RD, `SPI_CONFIG, 1, 64'd0);
      for (int b = 0; b < 4; b++)
         add_step(OP_WR, `SPI_USER_BASE + 6'(8*b), 8, {$random(seed), $random(seed)});
      add_step(OP_RD, `SPI_USER_BASE, 8, 64'd0);
      for (int k = 0; k < 3; k++)
         add_burst();
      add_step(OP_RD, 6'd60, 6, 64'd0);  // 60..63 then 0 and 1
      add_step(OP_RD, 6'd2, 6, 64'd0);   // reserved
      add_step(OP_RD, 6'd16, 8, 64'd0);
      add_step(OP_CORE, 6'd0, 0, {$random(seed), $random(seed)});
      add_step(OP_RD, `SPI_CORE_BASE, 8, 64'd0);
      add_step(OP_RD, `SPI_STATUS, 1, 64'd0);
      add_step(OP_RD, `SPI_STATUS, 1, 64'd0);  // cleared by the first read
      // level irq
      add_step(OP_MODE, `SPI_CONFIG, 0, 64'h02);
      add_step(OP_CORE, 6'd0, 0, {$random(seed), $random(seed)});
      add_step(OP_RD, `SPI_STATUS, 1, 64'd0);
      for (int m = 0; m < 8; m++)
      begin
         add_step(OP_MODE, `SPI_CONFIG, 0, {56'd0, modes[m]});
         add_burst();
      end
      add_step(OP_ABORT, 6'd45, 0, {56'd0, ~m_user[13]});  // byte 45
      add_step(OP_RD, 6'd45, 1, 64'd0);
   endfunction

   // ####################
   // host and core drivers
   // ####################
   task automatic half_bit();
      repeat (HALF_CYC) @(negedge clk);
   endtask

   task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx, input int nbits);
      int idx;
      rx = 8'd0;
      for (int i = 0; i < nbits; i++)
      begin
         idx = host_lsb ? i : 7 - i;
         if (!host_cpha)
         begin
            mosi = tx[idx];
            half_bit();
            rx[idx] = miso;
            sclk    = ~host_cpol;  // leading edge samples
            half_bit();
            sclk    = host_cpol;
         end
         else
         begin
            sclk = ~host_cpol;     // leading edge shifts
            mosi = tx[idx];
            half_bit();
            rx[idx] = miso;
            sclk    = host_cpol;   // trailing edge samples
            half_bit();
         end
      end
   endtask

   task automatic spi_frame(input logic [7:0] cmd, input int nbytes, input int tail_bits);
      logic [7:0] dummy;
      @(negedge clk);
      ss_n = 1'b0;
      half_bit();
      spi_byte(cmd, dummy, 8);
      for (int b = 0; b < nbytes; b++)
         spi_byte(tx_buf[b], rx_buf[b], 8);
      if (tail_bits > 0)
         spi_byte(tx_buf[nbytes], dummy, tail_bits);  // cut short
      half_bit();
      ss_n = 1'b1;
      mosi = 1'b0;
      half_bit();
      half_bit();
   endtask

   task automatic core_packet(input logic [63:0] word);
      @(negedge clk);
      packet_in.ctrl    = 8'hc3;
      packet_in.dstaddr = 32'h0808_0000;
      packet_in.data    = word[31:0];
      packet_in.srcaddr = word[63:32];
      access_in         = 1'b1;
      @(negedge clk);
      access_in = 1'b0;
      repeat (3) @(negedge clk);  // bytes and status two clk after the strobe
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      val_errs++;
   endtask

   task automatic apply_step(input step_t s);
      logic [5:0] exp_c;
      exp_c = {s.exp_cfg[`SPI_CFG_EMODE], s.exp_cfg[4:0]};  // cfg port layout
      case (s.op)
         OP_WR:
         begin
            for (int i = 0; i < 8; i++)
               tx_buf[i] = s.data[8*i +: 8];
            spi_frame({`SPI_CMD_WRITE, s.addr}, int'(s.len), 0);
         end
         OP_RD:
         begin
            for (int i = 0; i < 8; i++)
               tx_buf[i] = 8'h00;
            spi_frame({`SPI_CMD_READ, s.addr}, int'(s.len), 0);
            for (int i = 0; i < int'(s.len); i++)
               if (rx_buf[i] !== s.exp_bytes[8*i +: 8])
                  report_mismatch($sformatf("miso byte @%0d", s.addr + 6'(i)),
                                  s.exp_bytes[8*i +: 8], rx_buf[i]);
         end
         OP_CORE:
            core_packet(s.data);
         OP_MODE:
         begin
            tx_buf[0] = s.data[7:0];
            spi_frame({`SPI_CMD_WRITE, `SPI_CONFIG}, 1, 0);
            host_cpol = s.data[`SPI_CFG_CPOL];
            host_cpha = s.data[`SPI_CFG_CPHA];
            host_lsb  = s.data[`SPI_CFG_LSBFIRST];
            sclk      = host_cpol;  // new idle level while deselected
            half_bit();
         end
         default:
         begin
            tx_buf[0] = s.data[7:0];
            spi_frame({`SPI_CMD_WRITE, s.addr}, 0, 4);
         end
      endcase
      if (irq !== s.exp_irq)
         report_mismatch("irq", s.exp_irq, irq);
      if (cfg !== exp_c)
         report_mismatch("cfg", exp_c, cfg);
      if (spi_en !== ~s.exp_cfg[`SPI_CFG_DISABLE])
         report_mismatch("spi_en", ~s.exp_cfg[`SPI_CFG_DISABLE], spi_en);
      if (miso !== 1'b0)
         report_mismatch("miso", 64'd0, miso);  // idle while deselected
   endtask

   // ####################
   // main sequence
   // ####################
   initial
   begin
      seed        = 32'h5c19;
      nreset      = 1'b0;
      sclk        = 1'b0;
      ss_n        = 1'b1;
      mosi        = 1'b0;
      access_in   = 1'b0;
      packet_in   = '0;
      host_cpol   = 1'b0;
      host_cpha   = 1'b0;
      host_lsb    = 1'b0;
      val_errs    = 0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYC) @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      if (irq !== 1'b0)
         report_mismatch("irq", 1'b0, irq);
      if (spi_en !== 1'b1)
         report_mismatch("spi_en", 1'b1, spi_en);
      if (cfg !== '0)
         report_mismatch("cfg", 64'd0, cfg);
      if (miso !== 1'b0)
         report_mismatch("miso", 64'd0, miso);
      for (int i = 0; i < n_steps; i++)
         apply_step(steps[i]);
      $display("%0d steps, %0d value errors", n_steps, val_errs);
      if (val_errs == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   // watchdog sized from the table at 10 bytes per frame
   initial
   begin
      longint limit_ns;
      wait (table_ready);
      limit_ns = longint'(n_steps) * 10 * 8 * BIT_NS * 2 + RESET_CYC * 4;
      #(limit_ns);
      $display("watchdog expired after %0d ns before the table finished", limit_ns);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== spi_slave.f ====
+incdir+design
design/spi_slave_pkg.sv
design/spi_slave_io.sv
design/emesh_packet_unpack.sv
design/spi_slave_regs.sv
design/spi_slave.sv
verification/spi_slave_tb.sv

// ==== Makefile ====
# Verilator build and run for the SPI slave register port

VERILATOR ?= verilator
TOP       ?= spi_slave_tb
FILELIST  ?= spi_slave.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard design/*.sv design/*.svh verification/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# pass only if the testbench printed its pass line
run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
